// File: common/rv64_ctrl_pkg.sv
// Micro-op types: ALU op enum, branch condition enum, immediate format enum, control struct.
package rv64_ctrl_pkg;
  import rv64_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_IMM,
    ALU_ADDW,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_e;

  // Immediate layouts, used by the decoder only.
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

  // Decoded control. After execute, use_imm carries the taken flag.
  typedef struct packed {
    alu_op_e                 alu_op;
    branch_e                 branch;
    logic                    use_imm;
    logic                    a_is_pc;
    logic                    is_jump;
    logic                    is_jalr;
    logic                    reg_wen;
    logic                    mem_wen;
    logic                    mem_ren;
    logic                    is_ebreak;
    logic                    illegal;
    logic [REG_ADDR_W-1:0]   rd;
  } ctrl_t;

endpackage

// File: common/rv64_isa_pkg.sv
// RV64I encoding: data widths, instruction field widths, opcode enum, funct codes.
package rv64_isa_pkg;

  localparam int INST_W     = 32;
  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  // Major opcodes the decoder knows.
  typedef enum logic [OPCODE_W-1:0] {
    OP_IMM    = 7'b0010011,
    OP        = 7'b0110011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011,
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    SYSTEM    = 7'b1110011
  } opcode_e;

  // --------------------------------------------------
  // funct3 codes of the ALU and memory groups.
  // --------------------------------------------------
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;
  // Doubleword access width for ld and sd.
  localparam logic [FUNCT3_W-1:0] F3_D    = 3'b011;

  // funct7 of the base and alternate (sub, sra) forms.
  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

  // Bits 31..7 of ebreak.
  localparam logic [24:0] EBREAK_HI = {12'h001, 13'h0000};

endpackage

// File: common/stage_if.sv
// Interface stage_if: one instruction's state between two pipeline stages.
interface stage_if
  import rv64_isa_pkg::*, rv64_ctrl_pkg::*;
();

  logic                  valid;
  logic [XLEN-1:0]       pc;
  ctrl_t                 ctrl;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;
  // Source values, or the result and store data past execute.
  logic [XLEN-1:0]       a;
  logic [XLEN-1:0]       b;
  logic [XLEN-1:0]       imm;

  modport src (
    output valid, pc, ctrl, rs1_idx, rs2_idx, a, b, imm
  );

  modport dst (
    input valid, pc, ctrl, rs1_idx, rs2_idx, a, b, imm
  );

endinterface

// File: decode/decode_stage.sv
// Decode stage: decoder, register file read addresses, decode/execute pipeline register.
module decode_stage
  import rv64_isa_pkg::*, rv64_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  inst_valid,
  input  logic [INST_W-1:0]     inst,
  input  logic [XLEN-1:0]       pc,
  output logic [REG_ADDR_W-1:0] rs1_addr,
  output logic [REG_ADDR_W-1:0] rs2_addr,
  input  logic [XLEN-1:0]       rs1_data,
  input  logic [XLEN-1:0]       rs2_data,
  stage_if.src                  d2e
);

  ctrl_t           ctrl;
  logic [XLEN-1:0] imm;

  rv64_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  // Sources read unconditionally; unused ones are ignored later.
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d2e.valid <= 1'b0;
    end else begin
      d2e.valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      d2e.pc      <= pc;
      d2e.ctrl    <= ctrl;
      d2e.rs1_idx <= rs1_addr;
      d2e.rs2_idx <= rs2_addr;
      d2e.a       <= rs1_data;
      d2e.b       <= rs2_data;
      d2e.imm     <= imm;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(d2e.valid));

endmodule

// File: decode/rv64_decoder.sv
// Instruction decoder: control struct and sign-extended immediate from an instruction word.
module rv64_decoder
  import rv64_isa_pkg::*, rv64_ctrl_pkg::*;
(
  input  logic [INST_W-1:0] inst,
  output ctrl_t             ctrl,
  output logic [XLEN-1:0]   imm
);

  opcode_e             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  imm_fmt_e            fmt;
  logic                legal;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // --------------------------------------------------
  // Instruction match and control fields.
  // --------------------------------------------------
  always_comb begin
    ctrl    = '0;
    ctrl.rd = inst[11:7];
    fmt     = IMM_I;
    legal   = 1'b0;
    case (opcode)
      OP_IMM: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
        legal        = 1'b1;
        case (funct3)
          F3_ADD:  ctrl.alu_op = ALU_ADD;
          F3_SLT:  ctrl.alu_op = ALU_SLT;
          F3_SLTU: ctrl.alu_op = ALU_SLTU;
          F3_XOR:  ctrl.alu_op = ALU_XOR;
          F3_OR:   ctrl.alu_op = ALU_OR;
          F3_AND:  ctrl.alu_op = ALU_AND;
          F3_SLL: begin
            ctrl.alu_op = ALU_SLL;
            legal       = (inst[31:26] == 6'b000000);
          end
          default: begin
            // Six-bit shamt; bit 30 picks arithmetic.
            ctrl.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
            legal       = !inst[31] && (inst[29:26] == 4'b0000);
          end
        endcase
      end
      OP: begin
        ctrl.reg_wen = 1'b1;
        legal = (funct7 == F7_BASE) ||
                (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
        case (funct3)
          F3_ADD:  ctrl.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
          F3_SLL:  ctrl.alu_op = ALU_SLL;
          F3_SLT:  ctrl.alu_op = ALU_SLT;
          F3_SLTU: ctrl.alu_op = ALU_SLTU;
          F3_XOR:  ctrl.alu_op = ALU_XOR;
          F3_SR:   ctrl.alu_op = inst[30] ? ALU_SRA : ALU_SRL;
          F3_OR:   ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
      end
      OP_IMM_32, OP_32: begin
        ctrl.use_imm = (opcode == OP_IMM_32);
        ctrl.reg_wen = 1'b1;
        // Only addiw among the add forms; addw and subw are not supported.
        if (funct3 == F3_ADD) begin
          ctrl.alu_op = ALU_ADDW;
          legal       = (opcode == OP_IMM_32);
        end else if (funct3 == F3_SLL) begin
          ctrl.alu_op = ALU_SLLW;
          legal       = (funct7 == F7_BASE);
        end else if (funct3 == F3_SR) begin
          ctrl.alu_op = inst[30] ? ALU_SRAW : ALU_SRLW;
          legal       = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        end
      end
      LUI, AUIPC: begin
        ctrl.alu_op  = (opcode == LUI) ? ALU_PASS_IMM : ALU_ADD;
        ctrl.a_is_pc = (opcode == AUIPC);
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
        fmt          = IMM_U;
        legal        = 1'b1;
      end
      JAL, JALR: begin
        // ALU forms the target; rd gets pc+4 in execute.
        ctrl.a_is_pc = (opcode == JAL);
        ctrl.use_imm = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.is_jalr = (opcode == JALR);
        ctrl.reg_wen = 1'b1;
        fmt          = (opcode == JAL) ? IMM_J : IMM_I;
        legal        = (opcode == JAL) || (funct3 == F3_ADD);
      end
      BRANCH: begin
        ctrl.a_is_pc = 1'b1;
        ctrl.use_imm = 1'b1;
        fmt          = IMM_B;
        legal        = 1'b1;
        case (funct3)
          3'b000:  ctrl.branch = BR_EQ;
          3'b001:  ctrl.branch = BR_NE;
          3'b100:  ctrl.branch = BR_LT;
          3'b101:  ctrl.branch = BR_GE;
          3'b110:  ctrl.branch = BR_LTU;
          3'b111:  ctrl.branch = BR_GEU;
          default: legal = 1'b0;
        endcase
      end
      LOAD, STORE: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_ren = (opcode == LOAD);
        ctrl.reg_wen = (opcode == LOAD);
        ctrl.mem_wen = (opcode == STORE);
        fmt          = (opcode == STORE) ? IMM_S : IMM_I;
        legal        = (funct3 == F3_D);
      end
      SYSTEM: begin
        ctrl.is_ebreak = (inst[31:7] == EBREAK_HI);
        legal          = ctrl.is_ebreak;
      end
      default: legal = 1'b0;
    endcase

    // Unmatched encodings write nothing.
    if (!legal) begin
      ctrl         = '0;
      ctrl.rd      = inst[11:7];
      ctrl.illegal = 1'b1;
    end

    assert final ($onehot0({ctrl.mem_wen, ctrl.mem_ren}))
      else $error("decoder sets both mem_wen and mem_ren");
  end

  // Immediate select and sign extension.
  always_comb begin
    case (fmt)
      IMM_S:   imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B:   imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U:   imm = {{32{inst[31]}}, inst[31:12], 12'h000};
      IMM_J:   imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = {{52{inst[31]}}, inst[31:20]};
    endcase
  end

endmodule

// File: design/execute_stage.sv
// Execute stage with operand forwarding, ALU, branch resolution and execute/memory register.
module execute_stage
  import rv64_isa_pkg::*, rv64_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  stage_if.dst                  d2e,
  input  logic                  fwd_m_valid,
  input  logic [REG_ADDR_W-1:0] fwd_m_rd,
  input  logic [XLEN-1:0]       fwd_m_data,
  input  logic                  fwd_w_valid,
  input  logic [REG_ADDR_W-1:0] fwd_w_rd,
  input  logic [XLEN-1:0]       fwd_w_data,
  stage_if.src                  e2m
);

  logic [XLEN-1:0] rs1_val, rs2_val, op_a, op_b;
  logic [XLEN-1:0] alu_res, link, next_pc;
  logic [31:0]     word;
  logic            cond, taken;
  ctrl_t           ctrl_out;

  // Youngest producer wins; x0 keeps its zero.
  function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] idx,
                                           input logic [XLEN-1:0]       rd_val);
    if (idx == '0) return rd_val;
    if (fwd_m_valid && fwd_m_rd == idx) return fwd_m_data;
    if (fwd_w_valid && fwd_w_rd == idx) return fwd_w_data;
    return rd_val;
  endfunction

  // --------------------------------------------------
  // Operands and ALU.
  // --------------------------------------------------
  always_comb begin
    rs1_val = pick(d2e.rs1_idx, d2e.a);
    rs2_val = pick(d2e.rs2_idx, d2e.b);
    op_a    = d2e.ctrl.a_is_pc ? d2e.pc : rs1_val;
    op_b    = d2e.ctrl.use_imm ? d2e.imm : rs2_val;
    word    = '0;
    case (d2e.ctrl.alu_op)
      ALU_SUB:      alu_res = op_a - op_b;
      ALU_SLT:      alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:     alu_res = {63'b0, op_a < op_b};
      ALU_AND:      alu_res = op_a & op_b;
      ALU_OR:       alu_res = op_a | op_b;
      ALU_XOR:      alu_res = op_a ^ op_b;
      ALU_SLL:      alu_res = op_a << op_b[5:0];
      ALU_SRL:      alu_res = op_a >> op_b[5:0];
      ALU_SRA:      alu_res = $signed(op_a) >>> op_b[5:0];
      ALU_PASS_IMM: alu_res = op_b;
      ALU_ADDW, ALU_SLLW, ALU_SRLW, ALU_SRAW: begin
        case (d2e.ctrl.alu_op)
          ALU_ADDW: word = op_a[31:0] + op_b[31:0];
          ALU_SLLW: word = op_a[31:0] << op_b[4:0];
          ALU_SRLW: word = op_a[31:0] >> op_b[4:0];
          default:  word = $signed(op_a[31:0]) >>> op_b[4:0];
        endcase
        // Word results sign-extend from bit 31.
        alu_res = {{32{word[31]}}, word};
      end
      default:      alu_res = op_a + op_b;
    endcase
  end

  // Branch compare on the forwarded sources.
  always_comb begin
    case (d2e.ctrl.branch)
      BR_EQ:   cond = (rs1_val == rs2_val);
      BR_NE:   cond = (rs1_val != rs2_val);
      BR_LT:   cond = ($signed(rs1_val) < $signed(rs2_val));
      BR_GE:   cond = ($signed(rs1_val) >= $signed(rs2_val));
      BR_LTU:  cond = (rs1_val < rs2_val);
      BR_GEU:  cond = (rs1_val >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign taken   = d2e.ctrl.is_jump | cond;
  assign link    = d2e.pc + 64'd4;
  assign next_pc = taken ? {alu_res[XLEN-1:1], alu_res[0] & ~d2e.ctrl.is_jalr} : link;

  // use_imm is done with; it carries the taken flag from here on.
  always_comb begin
    ctrl_out         = d2e.ctrl;
    ctrl_out.use_imm = taken;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      e2m.valid <= 1'b0;
    end else begin
      e2m.valid <= d2e.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (d2e.valid) begin
      e2m.pc      <= d2e.pc;
      e2m.ctrl    <= ctrl_out;
      e2m.rs1_idx <= d2e.rs1_idx;
      e2m.rs2_idx <= d2e.rs2_idx;
      e2m.a       <= d2e.ctrl.is_jump ? link : alu_res;
      e2m.b       <= rs2_val;
      e2m.imm     <= next_pc;
    end
  end

  a_taken_only_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
    e2m.valid && e2m.ctrl.use_imm |-> e2m.ctrl.is_jump || e2m.ctrl.branch != BR_NONE);

endmodule

// File: design/memory_stage.sv
// Memory stage: doubleword data RAM, stage result, memory/writeback pipeline register.
module memory_stage
  import rv64_isa_pkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic                  clk,
  input  logic                  arst_n,
  stage_if.dst                  e2m,
  output logic                  fwd_m_valid,
  output logic [REG_ADDR_W-1:0] fwd_m_rd,
  output logic [XLEN-1:0]       fwd_m_data,
  stage_if.src                  m2w
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]  dmem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [XLEN-1:0]  result;

  // Doubleword index, wrapping at the RAM depth.
  assign idx = IDX_W'(e2m.a[XLEN-1:3] % DMEM_WORDS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dmem <= '{default: '0};
    end else if (e2m.valid && e2m.ctrl.mem_wen) begin
      dmem[idx] <= e2m.b;
    end
  end

  assign result      = e2m.ctrl.mem_ren ? dmem[idx] : e2m.a;
  assign fwd_m_valid = e2m.valid & e2m.ctrl.reg_wen;
  assign fwd_m_rd    = e2m.ctrl.rd;
  assign fwd_m_data  = result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m2w.valid <= 1'b0;
    end else begin
      m2w.valid <= e2m.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (e2m.valid) begin
      m2w.pc      <= e2m.pc;
      m2w.ctrl    <= e2m.ctrl;
      m2w.rs1_idx <= e2m.rs1_idx;
      m2w.rs2_idx <= e2m.rs2_idx;
      m2w.a       <= result;
      m2w.b       <= e2m.b;
      m2w.imm     <= e2m.imm;
    end
  end

  a_no_illegal_access: assert property (@(posedge clk) disable iff (!arst_n)
    e2m.valid && e2m.ctrl.illegal |-> !(e2m.ctrl.mem_wen || e2m.ctrl.mem_ren));

endmodule

// File: design/reg_file.sv
// Integer register file: x1..x31, hard-wired x0, write-through reads.
module reg_file
  import rv64_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  wen,
  input  logic [REG_ADDR_W-1:0] wr_addr,
  input  logic [XLEN-1:0]       wr_data
);

  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (wen && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write is visible to the reader.
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    if (addr == '0) return '0;
    if (wen && addr == wr_addr) return wr_data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

// File: design/rv64_pipe_top.sv
// RV64I pipeline top: decode, execute and memory stages, register file, writeback ports.
module rv64_pipe_top
  import rv64_isa_pkg::*;
#(
  parameter int DMEM_WORDS = 64
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  inst_valid,
  input  logic [INST_W-1:0]     inst,
  input  logic [XLEN-1:0]       pc,
  output logic                  wb_valid,
  output logic [XLEN-1:0]       wb_pc,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic                  wb_wen,
  output logic [XLEN-1:0]       wb_data,
  output logic                  wb_taken,
  output logic [XLEN-1:0]       wb_next_pc,
  output logic                  wb_illegal,
  output logic                  wb_ebreak
);

  stage_if d2e ();
  stage_if e2m ();
  stage_if m2w ();

  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, fwd_m_rd;
  logic [XLEN-1:0]       rs1_data, rs2_data, fwd_m_data;
  logic                  fwd_m_valid;

  // --------------------------------------------------
  // Stages and register file.
  // --------------------------------------------------
  decode_stage u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .d2e        (d2e.src)
  );

  // Written from writeback at the end of the wb_valid cycle.
  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wb_wen),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data)
  );

  execute_stage u_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .d2e         (d2e.dst),
    .fwd_m_valid (fwd_m_valid),
    .fwd_m_rd    (fwd_m_rd),
    .fwd_m_data  (fwd_m_data),
    .fwd_w_valid (wb_wen),
    .fwd_w_rd    (wb_rd),
    .fwd_w_data  (wb_data),
    .e2m         (e2m.src)
  );

  memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_memory (
    .clk         (clk),
    .arst_n      (arst_n),
    .e2m         (e2m.dst),
    .fwd_m_valid (fwd_m_valid),
    .fwd_m_rd    (fwd_m_rd),
    .fwd_m_data  (fwd_m_data),
    .m2w         (m2w.src)
  );

  // Writeback report.
  assign wb_valid   = m2w.valid;
  assign wb_pc      = m2w.pc;
  assign wb_rd      = m2w.ctrl.rd;
  assign wb_wen     = m2w.valid & m2w.ctrl.reg_wen & ~m2w.ctrl.illegal;
  assign wb_data    = m2w.a;
  // Taken flag rides in the use_imm bit after execute.
  assign wb_taken   = m2w.valid & m2w.ctrl.use_imm;
  assign wb_next_pc = m2w.imm;
  assign wb_illegal = m2w.valid & m2w.ctrl.illegal;
  assign wb_ebreak  = m2w.valid & m2w.ctrl.is_ebreak;

endmodule

// File: rv64_pipe.f
common/rv64_isa_pkg.sv
common/rv64_ctrl_pkg.sv
common/stage_if.sv
decode/rv64_decoder.sv
decode/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv64_pipe_top.sv
verification/rv64_pipe_tb.sv

// File: verification/rv64_pipe_tb.sv
// rv64_pipe_top testbench with random instruction stream, architectural model and checks.
module rv64_pipe_tb;

  localparam int DMEM_WORDS  = 64;
  localparam int NUM_RANDOM  = 400;
  localparam int NUM_INST    = NUM_RANDOM + 13;
  localparam int MAX_CYCLES  = NUM_INST * 2 + 50;

  typedef struct packed {
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        wen;
    logic [63:0] data;
    logic        taken;
    logic [63:0] next_pc;
    logic        illegal;
    logic        ebreak;
  } exp_t;

  logic        clk;
  logic        arst_n;
  logic        inst_valid;
  logic [31:0] inst;
  logic [63:0] pc;
  logic        wb_valid;
  logic [63:0] wb_pc;
  logic [4:0]  wb_rd;
  logic        wb_wen;
  logic [63:0] wb_data;
  logic        wb_taken;
  logic [63:0] wb_next_pc;
  logic        wb_illegal;
  logic        wb_ebreak;

  exp_t        exp_q[$];
  exp_t        exp_e;
  logic [63:0] model_regs [32];
  logic [63:0] model_mem [DMEM_WORDS];
  logic [63:0] cur_pc;
  int          seed = 32'he239;
  int unsigned cycles = 0;

  rv64_pipe_top #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .wb_valid   (wb_valid),
    .wb_pc      (wb_pc),
    .wb_rd      (wb_rd),
    .wb_wen     (wb_wen),
    .wb_data    (wb_data),
    .wb_taken   (wb_taken),
    .wb_next_pc (wb_next_pc),
    .wb_illegal (wb_illegal),
    .wb_ebreak  (wb_ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic end_in_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      end_in_failure("writeback value differs from the model");
    end
  endtask

  // --------------------------------------------------
  // Encoders and random instruction source.
  // --------------------------------------------------
  function automatic logic [31:0] branch_inst(input logic [12:0] b, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [20:0] j, input logic [4:0] rd);
    return {j[20], j[10:1], j[11], j[19:12], rd, 7'h6f};
  endfunction

  // Sources and destinations stay in x0..x7; x8 is the memory base.
  function automatic logic [31:0] random_inst();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    r1  = $random(seed);
    r2  = $random(seed);
    rd  = {2'b00, r2[2:0]};
    rs1 = {2'b00, r2[5:3]};
    rs2 = {2'b00, r2[8:6]};
    f3  = r1[6:4];
    imm = r2[31:20];
    case (r1[3:0])
      4'd2, 4'd3: return {((f3 == 3'd0 || f3 == 3'd5) && r1[7]) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd, 7'h33};
      4'd4: begin
        f3 = (r1[5:4] == 2'd0) ? 3'd0 : (r1[5:4] == 2'd1) ? 3'd1 : 3'd5;
        if (f3 != 3'd0) imm = {1'b0, r1[7] & f3[2], 5'b0, imm[4:0]};
        return {imm, rs1, f3, rd, 7'h1b};
      end
      4'd5: begin
        f3 = r1[4] ? 3'd1 : 3'd5;
        return {(f3 == 3'd5 && r1[7]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h3b};
      end
      4'd6: return {r2[31:12], rd, r1[4] ? 7'h37 : 7'h17};
      4'd7: return r1[4] ? jal_inst({r2[31:12], 1'b0}, rd) : {imm, rs1, 3'd0, rd, 7'h67};
      4'd8, 4'd9: return branch_inst({imm, 1'b0}, rs2, rs1, (f3[2:1] == 2'b01) ? 3'd0 : f3);
      4'd10, 4'd11: begin
        // Small offsets, sometimes one RAM depth further to alias.
        imm = {2'b00, r1[10], 2'b00, r1[9:6], 3'b000};
        if (r1[11]) return {imm[11:5], rs2, 5'd8, 3'd3, imm[4:0], 7'h23};
        return {imm, 5'd8, 3'd3, rd, 7'h03};
      end
      4'd12: return 32'h00100073;
      4'd13: return r2;
      default: begin
        if (f3 == 3'd1) imm = {6'b0, imm[5:0]};
        if (f3 == 3'd5) imm = {1'b0, r1[7], 4'b0, imm[5:0]};
        return {imm, rs1, f3, rd, 7'h13};
      end
    endcase
  endfunction

  // --------------------------------------------------
  // Architectural model executing one instruction per call.
  // --------------------------------------------------
  function automatic logic [63:0] shift_right(input logic [63:0] v, input logic [5:0] sh,
                                              input logic arith);
    if (arith) return $signed(v) >>> sh;
    return v >> sh;
  endfunction

  task automatic run_model(input logic [31:0] w, input logic [63:0] cur);
    exp_t        e;
    logic [63:0] a, b, y, r, t, npc, ii, is, ib, iu, ij;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [5:0]  sh;
    logic        ok, wen, store, taken;
    int          idx;
    e     = '0;
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    ii    = {{52{w[31]}}, w[31:20]};
    is    = {{52{w[31]}}, w[31:25], w[11:7]};
    ib    = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    iu    = {{32{w[31]}}, w[31:12], 12'h000};
    ij    = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    ok    = 1'b1;
    wen   = 1'b0;
    store = 1'b0;
    taken = 1'b0;
    idx   = 0;
    r     = '0;
    t     = '0;
    npc   = cur + 64'd4;
    case (w[6:0])
      7'h13, 7'h33: begin
        wen = 1'b1;
        y   = w[5] ? b : ii;
        case (f3)
          3'd0:    r = (w[5] && w[30]) ? a - y : a + y;
          3'd1:    r = a << y[5:0];
          3'd2:    r = {63'b0, $signed(a) < $signed(y)};
          3'd3:    r = {63'b0, a < y};
          3'd4:    r = a ^ y;
          3'd5:    r = shift_right(a, y[5:0], w[30]);
          3'd6:    r = a | y;
          default: r = a & y;
        endcase
        if (w[5]) ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (f3 == 3'd1) ok = (w[31:26] == 6'h00);
        else if (f3 == 3'd5) ok = (w[31:26] == 6'h00 || w[31:26] == 6'h10);
      end
      7'h1b, 7'h3b: begin
        // Word forms use the low 32 bits and sign-extend from bit 31.
        wen = 1'b1;
        sh  = w[5] ? {1'b0, b[4:0]} : {1'b0, w[24:20]};
        case (f3)
          3'd0: begin
            ok = !w[5];
            t  = a + ii;
          end
          3'd1: begin
            ok = (f7 == 7'h00);
            t  = a << sh;
          end
          3'd5: begin
            ok = (f7 == 7'h00 || f7 == 7'h20);
            t  = shift_right(w[30] ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]}, sh, w[30]);
          end
          default: ok = 1'b0;
        endcase
        r = {{32{t[31]}}, t[31:0]};
      end
      7'h37: begin
        wen = 1'b1;
        r   = iu;
      end
      7'h17: begin
        wen = 1'b1;
        r   = cur + iu;
      end
      7'h6f, 7'h67: begin
        ok    = w[3] || (f3 == 3'd0);
        wen   = 1'b1;
        r     = cur + 64'd4;
        taken = 1'b1;
        npc   = w[3] ? cur + ij : (a + ii) & ~64'd1;
      end
      7'h63: begin
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          3'd7:    taken = (a >= b);
          default: ok = 1'b0;
        endcase
        if (taken) npc = cur + ib;
      end
      7'h03, 7'h23: begin
        ok    = (f3 == 3'd3);
        idx   = ((a + (w[5] ? is : ii)) >> 3) % DMEM_WORDS;
        wen   = !w[5];
        store = w[5];
        r     = model_mem[idx];
      end
      7'h73: begin
        ok       = (w[31:7] == 25'h0002000);
        e.ebreak = ok;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      wen   = 1'b0;
      store = 1'b0;
      taken = 1'b0;
      npc   = cur + 64'd4;
    end
    if (store) model_mem[idx] = b;
    if (wen && w[11:7] != 5'd0) model_regs[w[11:7]] = r;
    e.pc      = cur;
    e.rd      = w[11:7];
    e.wen     = wen;
    e.data    = r;
    e.taken   = taken;
    e.next_pc = npc;
    e.illegal = !ok;
    exp_q.push_back(e);
  endtask

  task automatic issue(input logic [31:0] w);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst       <= w;
    pc         <= cur_pc;
    run_model(w, cur_pc);
    cur_pc = cur_pc + 64'd4;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    inst_valid <= 1'b0;
    inst       <= '0;
  endtask

  // --------------------------------------------------
  // Checks.
  // --------------------------------------------------
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    inst_valid |-> ##3 (wb_valid && wb_pc == $past(pc, 3)))
    else end_in_failure("wb_valid or wb_pc wrong three cycles after issue");

  a_no_stray_wb: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> $past(inst_valid, 3))
    else end_in_failure("wb_valid seen without an instruction issued three cycles before");

  always @(posedge clk) begin
    if (arst_n && wb_valid) begin
      assert (exp_q.size() != 0)
        else end_in_failure("wb_valid seen with no pending instruction in the model");
      exp_e = exp_q.pop_front();
      check_value("wb_pc", wb_pc, exp_e.pc);
      check_value("wb_wen", wb_wen, exp_e.wen);
      check_value("wb_illegal", wb_illegal, exp_e.illegal);
      check_value("wb_ebreak", wb_ebreak, exp_e.ebreak);
      check_value("wb_taken", wb_taken, exp_e.taken);
      check_value("wb_next_pc", wb_next_pc, exp_e.next_pc);
      if (exp_e.wen) begin
        check_value("wb_rd", wb_rd, exp_e.rd);
        check_value("wb_data", wb_data, exp_e.data);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) end_in_failure("Timeout: the run did not finish in time.");
  end

  initial begin
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    cur_pc     = 64'h1000;
    model_regs = '{default: '0};
    model_mem  = '{default: '0};
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Base register, then store, load, load-use and an aliased load.
    issue({20'h12345, 5'd8, 7'h37});
    issue({12'h100, 5'd8, 3'd0, 5'd8, 7'h13});
    issue({12'hffb, 5'd0, 3'd0, 5'd1, 7'h13});
    issue({7'h00, 5'd1, 5'd8, 3'd3, 5'd16, 7'h23});
    issue({12'd16, 5'd8, 3'd3, 5'd2, 7'h03});
    issue({7'h00, 5'd2, 5'd2, 3'd0, 5'd3, 7'h33});
    issue({12'd528, 5'd8, 3'd3, 5'd4, 7'h03});
    // addiw wrapping past bit 31.
    issue({20'h80000, 5'd5, 7'h37});
    issue({12'hfff, 5'd5, 3'd0, 5'd5, 7'h1b});
    // Write to x0, then read it back.
    issue({12'd7, 5'd1, 3'd0, 5'd0, 7'h13});
    issue({7'h00, 5'd0, 5'd0, 3'd0, 5'd6, 7'h33});
    issue(32'h00100073);
    issue(32'hffffffff);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      issue(random_inst());
      if (($random(seed) & 7) == 0) idle_cycle();
    end
    idle_cycle();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
